// ==== rtl/sb_params.svh ====
`ifndef SB_PARAMS_SVH
`define SB_PARAMS_SVH

// architectural register count
`define SB_NREG 32

// pair tag width where tag 0 means no pending write
`define SB_TAG_W 3

// entries per lane buffer and reset credit count
`define SB_LANE_DEPTH 2

// longest pipe latency in cycles for class 3
`define SB_MAX_LAT 4

`endif

// ==== rtl/sb_pkg.sv ====
`default_nettype none

`include "sb_params.svh"

package sb_pkg;

  // architectural register number where r0 is never busy
  typedef logic [$clog2(`SB_NREG)-1:0] reg_addr_t;

  // pair tag running 1..7 then back to 1
  typedef logic [`SB_TAG_W-1:0] issue_tag_t;

  // pair tag with the slot bit below it
  typedef logic [`SB_TAG_W:0] prod_id_t;

  // latency class where the pipe takes class + 1 cycles
  typedef logic [$clog2(`SB_MAX_LAT)-1:0] lat_t;

  // lane head either empty or counting down
  typedef enum logic {
    LANE_IDLE,
    LANE_COUNT
  } lane_state_t;

endpackage

`default_nettype wire

// ==== rtl/mp_regfile_4r2w.sv ====
`default_nettype none

`include "sb_params.svh"

module mp_regfile_4r2w #(
  parameter int WIDTH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  sb_pkg::reg_addr_t ra_i [4],
  input  sb_pkg::reg_addr_t wa_i [2],
  input  logic              we_i [2],
  input  logic [WIDTH-1:0]  wd_i [2],
  output logic [WIDTH-1:0]  rd_o [4]
);

  logic [WIDTH-1:0] mem [`SB_NREG];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `SB_NREG; i++) begin
        mem[i] <= '0;
      end
    end else begin
      // port 1 lands last and wins on a shared address
      if (we_i[0]) begin
        mem[wa_i[0]] <= wd_i[0];
      end
      if (we_i[1]) begin
        mem[wa_i[1]] <= wd_i[1];
      end
    end
  end

  // async read ports
  for (genvar r = 0; r < 4; r++) begin : g_rd
    assign rd_o[r] = mem[ra_i[r]];
  end

  // the writers upstream must never collide on a live register
  a_no_dual_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(we_i[0] && we_i[1] && (wa_i[0] == wa_i[1]) && (wa_i[0] != '0))
  ) else begin
    $error("regfile: both ports write r%0d", wa_i[0]);
  end

endmodule

`default_nettype wire

// ==== rtl/scoreboard.sv ====
`default_nettype none

module scoreboard (
  input  logic               clk,
  input  logic               rst_n,
  input  sb_pkg::reg_addr_t  src_addr_i [4],
  output logic               src_rdy_o [4],
  input  sb_pkg::reg_addr_t  dst_addr_i [2],
  input  logic               issue_i [2],
  output sb_pkg::issue_tag_t tag_o,
  input  sb_pkg::reg_addr_t  wb_addr_i [2],
  input  sb_pkg::issue_tag_t wb_tid_i [2],
  input  logic               wb_valid_i [2]
);
  import sb_pkg::*;

  issue_tag_t tag_q;
  issue_tag_t tag_d;
  prod_id_t   ib_wd [2];
  logic       ib_we [2];
  logic       cb_we [2];
  prod_id_t   ib_rd [4];
  issue_tag_t cb_rd [4];

  // one counter shared by both slots with the slot bit to tell them apart
  always_comb begin
    tag_d = tag_q;
    if (issue_i[0] || issue_i[1]) begin
      tag_d = (tag_q == '1) ? issue_tag_t'(1) : tag_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tag_q <= issue_tag_t'(1);
    end else begin
      tag_q <= tag_d;
    end
  end

  assign tag_o = tag_q;

  for (genvar k = 0; k < 2; k++) begin : g_wr
    assign ib_wd[k] = {tag_q, 1'(k)};
    // r0 stays at zero in both boards
    assign ib_we[k] = issue_i[k] && (dst_addr_i[k] != '0);
    assign cb_we[k] = wb_valid_i[k] && (wb_addr_i[k] != '0);
  end

  // ready once the last committed tag catches up with the last issued one
  for (genvar r = 0; r < 4; r++) begin : g_rdy
    assign src_rdy_o[r] = (ib_rd[r][$bits(prod_id_t)-1:1] == cb_rd[r]);
  end

  mp_regfile_4r2w #(.WIDTH($bits(prod_id_t))) u_issue_board (
    .clk,
    .rst_n,
    .ra_i (src_addr_i),
    .wa_i (dst_addr_i),
    .we_i (ib_we),
    .wd_i (ib_wd),
    .rd_o (ib_rd)
  );

  mp_regfile_4r2w #(.WIDTH($bits(issue_tag_t))) u_commit_board (
    .clk,
    .rst_n,
    .ra_i (src_addr_i),
    .wa_i (wb_addr_i),
    .we_i (cb_we),
    .wd_i (wb_tid_i),
    .rd_o (cb_rd)
  );

  a_tag_nonzero: assert property (@(posedge clk) disable iff (!rst_n) tag_q != '0)
    else begin
      $error("scoreboard: issue tag reached 0");
    end

endmodule

`default_nettype wire

// ==== rtl/issue_ctrl.sv ====
`default_nettype none

`include "sb_params.svh"

module issue_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid_i,
  input  logic               in_slot1_valid_i,
  input  sb_pkg::reg_addr_t  in_src_i [2][2],
  input  sb_pkg::reg_addr_t  in_dst_i [2],
  input  sb_pkg::lat_t       in_lat_i [2],
  output logic               in_ready_o,
  output sb_pkg::reg_addr_t  sb_src_o [4],
  input  logic               sb_rdy_i [4],
  input  sb_pkg::issue_tag_t sb_tag_i,
  output logic               issue_o [2],
  output sb_pkg::reg_addr_t  lane_dst_o [2],
  output sb_pkg::lat_t       lane_lat_o [2],
  input  logic               lane_credit_i [2],
  output logic               issue_valid_o [2],
  output sb_pkg::issue_tag_t issue_tid_o
);

  localparam int CRED_W = $clog2(`SB_LANE_DEPTH + 1);

  logic [CRED_W-1:0] credit_q [2];
  logic              has_credit [2];
  logic              src_ok [2];
  logic              pair_raw;
  logic              pair_waw;

  for (genvar s = 0; s < 2; s++) begin : g_slot
    assign sb_src_o[2*s]     = in_src_i[s][0];
    assign sb_src_o[2*s + 1] = in_src_i[s][1];
    assign src_ok[s]         = sb_rdy_i[2*s] && sb_rdy_i[2*s + 1];
    assign has_credit[s]     = (credit_q[s] != '0);
    assign lane_dst_o[s]     = in_dst_i[s];
    assign lane_lat_o[s]     = in_lat_i[s];
    assign issue_valid_o[s]  = issue_o[s];
  end

  // slot 1 must not read or overwrite what slot 0 produces
  assign pair_raw = (in_dst_i[0] != '0) &&
                    ((in_src_i[1][0] == in_dst_i[0]) || (in_src_i[1][1] == in_dst_i[0]));
  assign pair_waw = (in_dst_i[0] != '0) && (in_dst_i[1] == in_dst_i[0]);

  // strict program order where slot 1 never goes alone
  assign issue_o[0] = in_valid_i && src_ok[0] && has_credit[0];
  assign issue_o[1] = issue_o[0] && in_slot1_valid_i && src_ok[1] && has_credit[1] &&
                      !pair_raw && !pair_waw;

  assign in_ready_o  = issue_o[0];
  assign issue_tid_o = sb_tag_i;

  // a returned credit is usable from the next cycle on
  for (genvar k = 0; k < 2; k++) begin : g_credit
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        credit_q[k] <= CRED_W'(`SB_LANE_DEPTH);
      end else begin
        credit_q[k] <= credit_q[k] - CRED_W'(issue_o[k]) + CRED_W'(lane_credit_i[k]);
      end
    end

    a_credit_range: assert property (
      @(posedge clk) disable iff (!rst_n) credit_q[k] <= CRED_W'(`SB_LANE_DEPTH)
    ) else begin
      $error("issue_ctrl: lane %0d credit count %0d out of range", k, credit_q[k]);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/exec_lane.sv ====
`default_nettype none

`include "sb_params.svh"

module exec_lane (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               push_i,
  input  sb_pkg::reg_addr_t  dst_i,
  input  sb_pkg::issue_tag_t tag_i,
  input  sb_pkg::lat_t       lat_i,
  output logic               done_o,
  output sb_pkg::reg_addr_t  done_dst_o,
  output sb_pkg::issue_tag_t done_tag_o,
  output logic               credit_o
);
  import sb_pkg::*;

  localparam int DEPTH = `SB_LANE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  reg_addr_t        dst_q [DEPTH];
  issue_tag_t       tag_q [DEPTH];
  lat_t             cnt_q [DEPTH];
  logic [DEPTH-1:0] vld_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  lane_state_t      state_q;
  lane_state_t      state_d;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    ptr_inc = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // head leaves only when its own countdown is spent
  assign done_o     = (state_q == LANE_COUNT) && (cnt_q[rd_ptr_q] == '0);
  assign done_dst_o = dst_q[rd_ptr_q];
  assign done_tag_o = tag_q[rd_ptr_q];
  assign credit_o   = done_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      LANE_IDLE: begin
        if (push_i) begin
          state_d = LANE_COUNT;
        end
      end
      LANE_COUNT: begin
        // stay busy if a younger entry waits or arrives now
        if (done_o && !vld_q[ptr_inc(rd_ptr_q)] && !push_i) begin
          state_d = LANE_IDLE;
        end
      end
      default: begin
        state_d = LANE_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q  <= LANE_IDLE;
      vld_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      state_q <= state_d;
      if (push_i) begin
        vld_q[wr_ptr_q] <= 1'b1;
        wr_ptr_q        <= ptr_inc(wr_ptr_q);
      end
      if (done_o) begin
        vld_q[rd_ptr_q] <= 1'b0;
        rd_ptr_q        <= ptr_inc(rd_ptr_q);
      end
    end
  end

  // every entry counts down from push even behind a stalled head
  always_ff @(posedge clk) begin
    for (int e = 0; e < DEPTH; e++) begin
      if (push_i && (wr_ptr_q == PTR_W'(e))) begin
        dst_q[e] <= dst_i;
        tag_q[e] <= tag_i;
        cnt_q[e] <= lat_i;
      end else if (cnt_q[e] != '0) begin
        cnt_q[e] <= cnt_q[e] - 1'b1;
      end
    end
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push_i |-> !(&vld_q))
    else begin
      $error("exec_lane: push into a full buffer");
    end

endmodule

`default_nettype wire

// ==== rtl/wb_drain.sv ====
`default_nettype none

module wb_drain (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               done_i [2],
  input  sb_pkg::reg_addr_t  done_dst_i [2],
  input  sb_pkg::issue_tag_t done_tag_i [2],
  output logic               wb_valid_o [2],
  output sb_pkg::reg_addr_t  wb_addr_o [2],
  output sb_pkg::issue_tag_t wb_tid_o [2]
);

  // every completion is taken so lanes never stall here
  for (genvar k = 0; k < 2; k++) begin : g_port
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        wb_valid_o[k] <= 1'b0;
      end else begin
        wb_valid_o[k] <= done_i[k];
      end
    end

    // address and tag only move with a completion
    always_ff @(posedge clk) begin
      if (done_i[k]) begin
        wb_addr_o[k] <= done_dst_i[k];
        wb_tid_o[k]  <= done_tag_i[k];
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/sb_backend_top.sv ====
`default_nettype none

module sb_backend_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid_i,
  input  logic               in_slot1_valid_i,
  input  sb_pkg::reg_addr_t  in_src_i [2][2],
  input  sb_pkg::reg_addr_t  in_dst_i [2],
  input  sb_pkg::lat_t       in_lat_i [2],
  output logic               in_ready_o,
  output logic               issue_valid_o [2],
  output sb_pkg::issue_tag_t issue_tid_o,
  output logic               wb_valid_o [2],
  output sb_pkg::reg_addr_t  wb_addr_o [2],
  output sb_pkg::issue_tag_t wb_tid_o [2]
);
  import sb_pkg::*;

  reg_addr_t  sb_src [4];
  logic       sb_rdy [4];
  issue_tag_t sb_tag;
  logic       issue_go [2];
  reg_addr_t  lane_dst [2];
  lat_t       lane_lat [2];
  logic       lane_credit [2];
  logic       lane_done [2];
  reg_addr_t  lane_done_dst [2];
  issue_tag_t lane_done_tag [2];

  issue_ctrl u_issue (
    .clk,
    .rst_n,
    .in_valid_i,
    .in_slot1_valid_i,
    .in_src_i,
    .in_dst_i,
    .in_lat_i,
    .in_ready_o,
    .sb_src_o      (sb_src),
    .sb_rdy_i      (sb_rdy),
    .sb_tag_i      (sb_tag),
    .issue_o       (issue_go),
    .lane_dst_o    (lane_dst),
    .lane_lat_o    (lane_lat),
    .lane_credit_i (lane_credit),
    .issue_valid_o,
    .issue_tid_o
  );

  // commit board is fed from the registered writeback
  scoreboard u_scoreboard (
    .clk,
    .rst_n,
    .src_addr_i (sb_src),
    .src_rdy_o  (sb_rdy),
    .dst_addr_i (lane_dst),
    .issue_i    (issue_go),
    .tag_o      (sb_tag),
    .wb_addr_i  (wb_addr_o),
    .wb_tid_i   (wb_tid_o),
    .wb_valid_i (wb_valid_o)
  );

  // lane k serves slot k and so implies the slot bit
  for (genvar k = 0; k < 2; k++) begin : g_lane
    exec_lane u_lane (
      .clk,
      .rst_n,
      .push_i     (issue_go[k]),
      .dst_i      (lane_dst[k]),
      .tag_i      (issue_tid_o),
      .lat_i      (lane_lat[k]),
      .done_o     (lane_done[k]),
      .done_dst_o (lane_done_dst[k]),
      .done_tag_o (lane_done_tag[k]),
      .credit_o   (lane_credit[k])
    );
  end

  wb_drain u_drain (
    .clk,
    .rst_n,
    .done_i     (lane_done),
    .done_dst_i (lane_done_dst),
    .done_tag_i (lane_done_tag),
    .wb_valid_o,
    .wb_addr_o,
    .wb_tid_o
  );

endmodule

`default_nettype wire

// ==== testbench/tb_sb_backend.sv ====
`default_nettype none

`include "sb_params.svh"

module tb_sb_backend;
  import sb_pkg::*;

  localparam int MAX_LINES = 64;

  logic       clk;
  logic       rst_n;
  logic       in_valid;
  logic       in_slot1_valid;
  reg_addr_t  in_src [2][2];
  reg_addr_t  in_dst [2];
  lat_t       in_lat [2];
  logic       in_ready;
  logic       issue_valid [2];
  issue_tag_t issue_tid;
  logic       wb_valid [2];
  reg_addr_t  wb_addr [2];
  issue_tag_t wb_tid [2];

  // one row per pair with the columns of the data file
  int         rows [MAX_LINES][10];
  int         n_lines;

  // reference model state
  issue_tag_t busy [`SB_NREG];
  int         credits [2];
  issue_tag_t model_tag;
  reg_addr_t  pend_dst [2][$];
  issue_tag_t pend_tag [2][$];
  logic       iss0;
  logic       iss1;

  sb_backend_top dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_valid_i       (in_valid),
    .in_slot1_valid_i (in_slot1_valid),
    .in_src_i         (in_src),
    .in_dst_i         (in_dst),
    .in_lat_i         (in_lat),
    .in_ready_o       (in_ready),
    .issue_valid_o    (issue_valid),
    .issue_tid_o      (issue_tid),
    .wb_valid_o       (wb_valid),
    .wb_addr_o        (wb_addr),
    .wb_tid_o         (wb_tid)
  );

  always #2 clk = ~clk;

  task automatic stop_run();
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_tag(input string name, input issue_tag_t got, input issue_tag_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s is r%0d, expected r%0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  function automatic logic is_busy(input reg_addr_t r);
    is_busy = (r != '0) && (busy[r] != '0);
  endfunction

  task automatic load_lines();
    int    fd;
    int    code;
    int    got;
    int    cnt;
    string text;
    int    f [10];
    cnt = 0;
    fd = $fopen("testbench/sb_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/sb_testdata.txt");
      stop_run();
    end
    while (!$feof(fd) && cnt < MAX_LINES) begin
      code = $fgets(text, fd);
      if (code > 0 && text.getc(0) != "#") begin
        got = $sscanf(text, "%d %d %d %d %d %d %d %d %d %d",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
        if (got == 10) begin
          for (int c = 0; c < 10; c++) begin
            rows[cnt][c] = f[c];
          end
          cnt++;
        end
      end
    end
    $fclose(fd);
    if (cnt == 0) begin
      $display("the data file holds no instruction pairs");
      stop_run();
    end
    n_lines = cnt;
  endtask

  // predict issue from the busy table and credits and compare
  task automatic eval_cycle();
    logic      go [2];
    logic      pair_dep;
    reg_addr_t d;
    // a writeback seen now means the credit is already back
    for (int k = 0; k < 2; k++) begin
      if (wb_valid[k]) begin
        credits[k]++;
      end
    end
    pair_dep = (in_dst[0] != '0) &&
               ((in_src[1][0] == in_dst[0]) || (in_src[1][1] == in_dst[0]) ||
                (in_dst[1] == in_dst[0]));
    go[0] = in_valid && !is_busy(in_src[0][0]) && !is_busy(in_src[0][1]) && (credits[0] > 0);
    go[1] = go[0] && in_slot1_valid && !is_busy(in_src[1][0]) && !is_busy(in_src[1][1]) &&
            (credits[1] > 0) && !pair_dep;
    check_flag("issue_valid_o[0]", issue_valid[0], go[0]);
    check_flag("issue_valid_o[1]", issue_valid[1], go[1]);
    check_flag("in_ready_o", in_ready, go[0]);
    if (go[0]) begin
      check_tag("issue_tid_o", issue_tid, model_tag);
    end
    // writebacks free a source only from the next cycle on
    for (int k = 0; k < 2; k++) begin
      if (wb_valid[k]) begin
        if (pend_dst[k].size() == 0) begin
          $display("error at %0t: lane %0d wrote back with nothing in flight", $time, k);
          stop_run();
        end
        check_addr($sformatf("wb_addr_o[%0d]", k), wb_addr[k], pend_dst[k][0]);
        check_tag($sformatf("wb_tid_o[%0d]", k), wb_tid[k], pend_tag[k][0]);
        d = wb_addr[k];
        if (d != '0 && busy[d] == wb_tid[k]) begin
          busy[d] = '0;
        end
        void'(pend_dst[k].pop_front());
        void'(pend_tag[k].pop_front());
      end
    end
    for (int s = 0; s < 2; s++) begin
      if (go[s]) begin
        if (in_dst[s] != '0) begin
          busy[in_dst[s]] = model_tag;
        end
        credits[s]--;
        pend_dst[s].push_back(in_dst[s]);
        pend_tag[s].push_back(model_tag);
      end
    end
    // tag runs 1..7 and skips the reserved zero
    if (go[0]) begin
      model_tag = (model_tag == issue_tag_t'(7)) ? issue_tag_t'(1) : model_tag + issue_tag_t'(1);
    end
    iss0 = go[0];
    iss1 = go[1];
  endtask

  task automatic run_cycle();
    @(negedge clk);
    eval_cycle();
    @(posedge clk);
    #1;
  endtask

  // hold the pair until slot 0 goes and move slot 1 down after a split
  task automatic issue_line(input int i);
    logic first;
    logic done;
    first = 1'b1;
    done = 1'b0;
    in_valid = 1'b1;
    in_src[0][0] = reg_addr_t'(rows[i][0]);
    in_src[0][1] = reg_addr_t'(rows[i][1]);
    in_dst[0] = reg_addr_t'(rows[i][2]);
    in_lat[0] = lat_t'(rows[i][3]);
    in_slot1_valid = (rows[i][4] != 0);
    in_src[1][0] = reg_addr_t'(rows[i][5]);
    in_src[1][1] = reg_addr_t'(rows[i][6]);
    in_dst[1] = reg_addr_t'(rows[i][7]);
    in_lat[1] = lat_t'(rows[i][8]);
    while (!done) begin
      run_cycle();
      if (iss0) begin
        if (first) begin
          check_count($sformatf("issue count of line %0d", i + 1),
                      int'(iss0) + int'(iss1), rows[i][9]);
        end
        if (in_slot1_valid && !iss1) begin
          in_src[0][0] = in_src[1][0];
          in_src[0][1] = in_src[1][1];
          in_dst[0] = in_dst[1];
          in_lat[0] = in_lat[1];
          in_slot1_valid = 1'b0;
          in_src[1][0] = '0;
          in_src[1][1] = '0;
          in_dst[1] = '0;
          in_lat[1] = '0;
          first = 1'b0;
        end else begin
          done = 1'b1;
        end
      end
    end
    in_valid = 1'b0;
  endtask

  initial begin
    int gap;
    int leftover;
    void'($urandom(97130));
    clk = 1'b0;
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_slot1_valid = 1'b0;
    for (int s = 0; s < 2; s++) begin
      in_src[s][0] = '0;
      in_src[s][1] = '0;
      in_dst[s] = '0;
      in_lat[s] = '0;
      credits[s] = `SB_LANE_DEPTH;
    end
    for (int r = 0; r < `SB_NREG; r++) begin
      busy[r] = '0;
    end
    model_tag = issue_tag_t'(1);
    load_lines();
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < n_lines; i++) begin
      gap = $urandom % 3;
      repeat (gap) begin
        run_cycle();
      end
      issue_line(i);
    end
    while (pend_dst[0].size() != 0 || pend_dst[1].size() != 0) begin
      run_cycle();
    end
    // a few quiet cycles catch stray writebacks
    repeat (4) begin
      run_cycle();
    end
    leftover = 0;
    for (int r = 0; r < `SB_NREG; r++) begin
      if (busy[r] != '0) begin
        leftover++;
      end
    end
    if (leftover == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("%0d registers are still marked busy after the drain", leftover);
      stop_run();
    end
  end

  // budget of 40 cycles per pair plus reset
  initial begin
    wait (n_lines > 0);
    #((n_lines * 40 + 8) * 4);
    $display("timeout: the run did not finish within %0d cycles", n_lines * 40 + 8);
    stop_run();
  end

endmodule

`default_nettype wire

// ==== testbench/sb_testdata.txt ====
# slot0: src0 src1 dst lat | slot1: valid src0 src1 dst lat | slots issued in first issuing cycle
# decimal fields; registers r20..r31 are only read, never written
20 21  1 0   1 22 23  2 0   2
 1  2  3 1   1 24  0  4 1   2
 3  0  5 2   1  5 20  6 1   1
 0  0  0 3   1  0 25  0 0   2
 0  0  7 0   1  0  0  0 0   2
 7  0  8 0   0  0  0  0 0   1
 8  8  9 3   1 26 27 10 3   2
20 21 11 3   1 28 29 12 3   2
22 23 13 3   1 30 31 14 2   2
 9 10 15 0   1 15  0 16 0   1
11 12 17 1   1 20  0 17 0   1
17 13 18 2   1 14  0 19 0   2
18 19  1 3   1 20 21  2 3   2
20  0  3 3   1 21  0  4 3   2
22  0  5 3   1 23  0  7 2   2
 1  2  8 0   1  8  0  9 0   1
 3  4 10 1   1  0  0  0 1   2
 0  0 11 0   0  0  0  0 0   1
 5  7 16 2   1 24 25 13 1   2
 9 10 12 1   1 12  0 17 0   1
17 18 19 0   1 26  0  1 0   2
19  1  0 0   0  0  0  0 0   1

// ==== flist.f ====
+incdir+rtl
rtl/sb_pkg.sv
rtl/mp_regfile_4r2w.sv
rtl/scoreboard.sv
rtl/issue_ctrl.sv
rtl/exec_lane.sv
rtl/wb_drain.sv
rtl/sb_backend_top.sv
testbench/tb_sb_backend.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the scoreboard backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sb_backend -f flist.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0
